/* run_sim.sh */
#!/usr/bin/env bash
# Compile the flash subsystem with its testbench and run it under Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module flash_subsystem_tb \
    -f src.f -o flash_sim > build.log 2>&1 \
    || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/flash_sim > sim.log 2>&1 \
    || { echo "Simulation exited with an error, see sim.log"; exit 1; }
grep -qx "ALL CHECKS PASSED" sim.log \
    && { echo "Simulation passed"; exit 0; } \
    || { echo "Simulation failed, see sim.log"; exit 1; }

/* source/boot_copier.sv */
// ==================================================================
// Boot copier
// Reads the boot block word by word over the read bus, writes each
// word into program RAM and flags completion
// ==================================================================

`timescale 1ns/1ps

module boot_copier (
    input  logic clk_2x,
    input  logic reset,
    input  logic boot_start,
    flash_read_if.client bus,
    output logic ram_we,
    output logic [flash_pkg::ram_addr_width-1:0] ram_addr,
    output logic [flash_pkg::word_width-1:0] ram_wdata,
    output logic boot_done
);
    import flash_pkg::*;

    copier_state_e state;
    logic req_q;
    // Word index within the boot block, doubles as the RAM address
    logic [ram_addr_width-1:0] index_q;

    assign bus.req = req_q;
    assign bus.addr = boot_base + addr_width'(index_q);

    always_ff @(posedge clk_2x) begin
        if (reset) begin
            state <= cp_idle;
            req_q <= 1'b0;
            index_q <= '0;
            ram_we <= 1'b0;
            boot_done <= 1'b0;
        end else begin
            // Write strobe lasts a single cycle
            ram_we <= 1'b0;
            case (state)
                cp_idle: begin
                    if (boot_start) begin
                        index_q <= '0;
                        req_q <= 1'b1;
                        state <= cp_request;
                    end
                end
                cp_request: begin
                    if (bus.ack) begin
                        req_q <= 1'b0;
                        ram_we <= 1'b1;
                        state <= cp_wait_release;
                    end
                end
                cp_wait_release: begin
                    // Next request only once the previous handshake is closed
                    if (!bus.ack) begin
                        if (index_q == ram_addr_width'(boot_words - 1)) begin
                            boot_done <= 1'b1;
                            state <= cp_done;
                        end else begin
                            index_q <= index_q + 1'b1;
                            req_q <= 1'b1;
                            state <= cp_request;
                        end
                    end
                end
                default: begin
                end
            endcase
        end
    end

    // RAM payload is taken while ack is high and data is valid
    always_ff @(posedge clk_2x) begin
        if (state == cp_request && bus.ack) begin
            ram_addr <= index_q;
            ram_wdata <= bus.data;
        end
    end

    a_no_write_after_done: assert property (@(posedge clk_2x) disable iff (reset)
        boot_done |-> !$rose(ram_we));

endmodule

/* source/flash_arbiter.sv */
// ==================================================================
// Two-client arbiter in front of the single flash reader
// Alternating priority, grant held for a full four-phase handshake
// ==================================================================

`timescale 1ns/1ps

module flash_arbiter (
    input  logic clk_2x,
    input  logic reset,
    flash_read_if.server boot,
    flash_read_if.server host,
    flash_read_if.client reader
);
    import flash_pkg::*;

    arb_state_e state;
    logic last_host;
    logic reader_req_q;
    logic boot_ack_q;
    logic host_ack_q;
    logic [addr_width-1:0] addr_q;
    logic [word_width-1:0] data_q;
    logic grant_boot;
    logic grant_host;

    // The client granted last time has the lower priority on a tie
    assign grant_boot = boot.req && (!host.req || last_host);
    assign grant_host = host.req && !grant_boot;

    assign reader.req = reader_req_q;
    assign reader.addr = addr_q;
    assign boot.ack = boot_ack_q;
    assign host.ack = host_ack_q;
    // Both clients see the same word; only the one with ack reads it
    assign boot.data = data_q;
    assign host.data = data_q;

    always_ff @(posedge clk_2x) begin
        if (reset) begin
            state <= arb_idle;
            last_host <= 1'b0;
            reader_req_q <= 1'b0;
            boot_ack_q <= 1'b0;
            host_ack_q <= 1'b0;
        end else begin
            case (state)
                arb_idle: begin
                    if (grant_boot) begin
                        reader_req_q <= 1'b1;
                        last_host <= 1'b0;
                        state <= arb_busy_boot;
                    end else if (grant_host) begin
                        reader_req_q <= 1'b1;
                        last_host <= 1'b1;
                        state <= arb_busy_host;
                    end
                end
                arb_busy_boot: begin
                    boot_ack_q <= reader.ack;
                    // Client has seen ack and let go, so close the reader side
                    if (boot_ack_q && !boot.req) begin
                        reader_req_q <= 1'b0;
                        state <= arb_release;
                    end
                end
                arb_busy_host: begin
                    host_ack_q <= reader.ack;
                    if (host_ack_q && !host.req) begin
                        reader_req_q <= 1'b0;
                        state <= arb_release;
                    end
                end
                default: begin
                    // Ack falls towards the granted client one cycle after the reader
                    boot_ack_q <= reader.ack && !last_host;
                    host_ack_q <= reader.ack && last_host;
                    if (!reader.ack) begin
                        state <= arb_idle;
                    end
                end
            endcase
        end
    end

    // Address is captured on grant, data whenever the reader presents it
    always_ff @(posedge clk_2x) begin
        if (state == arb_idle) begin
            addr_q <= grant_host ? host.addr : boot.addr;
        end
        if (reader.ack) begin
            data_q <= reader.data;
        end
    end

    a_single_ack: assert property (@(posedge clk_2x) disable iff (reset)
        !(boot.ack && host.ack));

    a_req_after_ack: assert property (@(posedge clk_2x) disable iff (reset)
        $rose(reader.req) |-> !reader.ack);

endmodule

/* source/flash_pin_adapter.sv */
// ==================================================================
// Flash pad stage
// Registers chip select, data and enables out, flash data in, and
// builds the DDR clock pair for the pad logic
// ==================================================================

`timescale 1ns/1ps

module flash_pin_adapter (
    input  logic clk_2x,
    input  logic reset,
    input  logic csn,
    input  logic [3:0] io_out,
    input  logic [3:0] io_en,
    input  logic sck_run,
    output logic [3:0] io_in,
    output logic [1:0] flash_clk_ddr,
    output logic flash_csn,
    output logic [3:0] flash_in_en,
    output logic [3:0] flash_in,
    input  logic [3:0] flash_out
);

    // Control pins come out of reset as an idle, deselected bus
    always_ff @(posedge clk_2x) begin
        if (reset) begin
            flash_csn <= 1'b1;
            flash_in_en <= 4'b0000;
            flash_clk_ddr <= 2'b00;
        end else begin
            flash_csn <= csn;
            flash_in_en <= io_en;
            // High half only, giving one serial clock per clk_2x cycle
            // with the rising edge at the start of the cycle
            flash_clk_ddr <= {1'b0, sck_run};
        end
    end

    // Data lines in both directions, one register stage each
    always_ff @(posedge clk_2x) begin
        flash_in <= io_out;
        io_in <= flash_out;
    end

endmodule

/* source/flash_pkg.sv */
// ==================================================================
// Shared definitions of the quad-SPI flash read path
// Word and address widths, boot block constants, the flash command
// opcode and the state encodings of the reader, arbiter and copier
// ==================================================================

package flash_pkg;

    // Data words handed to clients, and word addresses into the flash
    localparam int word_width = 32;
    localparam int addr_width = 22;

    // The boot block starts at this word and spans boot_words words
    localparam logic [addr_width-1:0] boot_base = 64;
    localparam int boot_words = 16;

    // Program RAM is addressed by word
    localparam int ram_addr_width = 8;

    // Serial clocks between the address and the first data nibble
    localparam int dummy_cycles = 8;

    // Only the quad output fast read is ever issued
    typedef enum logic [7:0] {
        cmd_quad_read = 8'h6B
    } flash_cmd_e;

    typedef enum logic [2:0] {
        rd_idle, rd_command, rd_address, rd_dummy, rd_data, rd_finish
    } reader_state_e;

    typedef enum logic [1:0] {
        arb_idle, arb_busy_boot, arb_busy_host, arb_release
    } arb_state_e;

    typedef enum logic [1:0] {
        cp_idle, cp_request, cp_wait_release, cp_done
    } copier_state_e;

endpackage

/* source/flash_read_if.sv */
// ==================================================================
// Four-phase word read interface between flash clients and servers
// Client modport drives req and addr, server drives ack and data
// ==================================================================

`timescale 1ns/1ps

interface flash_read_if;
    import flash_pkg::*;

    // Request from the client, held until ack is seen
    logic req;
    // Answer from the server, held until req is seen low
    logic ack;
    // Word address, stable for as long as req is high
    logic [addr_width-1:0] addr;
    // Returned word, valid for as long as ack is high
    logic [word_width-1:0] data;

    modport client (
        output req, addr,
        input  ack, data
    );

    modport server (
        input  req, addr,
        output ack, data
    );

endinterface

/* source/flash_subsystem.sv */
// ==================================================================
// Flash read subsystem top level
// Boot copier and host port share one quad-SPI reader through the
// arbiter, with the pad stage on the flash side
// ==================================================================

`timescale 1ns/1ps

module flash_subsystem (
    input  logic clk_2x,
    input  logic reset,
    input  logic boot_start,
    input  logic host_req,
    input  logic [flash_pkg::addr_width-1:0] host_addr,
    output logic host_ack,
    output logic [flash_pkg::word_width-1:0] host_data,
    output logic ram_we,
    output logic [flash_pkg::ram_addr_width-1:0] ram_addr,
    output logic [flash_pkg::word_width-1:0] ram_wdata,
    output logic boot_done,
    output logic [1:0] flash_clk_ddr,
    output logic flash_csn,
    output logic [3:0] flash_in_en,
    output logic [3:0] flash_in,
    input  logic [3:0] flash_out
);

    flash_read_if boot_bus ();
    flash_read_if host_bus ();
    flash_read_if reader_bus ();

    // Pad values between the reader and the pad stage
    logic csn;
    logic [3:0] io_out;
    logic [3:0] io_en;
    logic sck_run;
    logic [3:0] io_in;

    // Host port acts as the client side of host_bus
    assign host_bus.req = host_req;
    assign host_bus.addr = host_addr;
    assign host_ack = host_bus.ack;
    assign host_data = host_bus.data;

    boot_copier copier_i (.clk_2x(clk_2x), .reset(reset), .boot_start(boot_start),
        .bus(boot_bus.client), .ram_we(ram_we), .ram_addr(ram_addr),
        .ram_wdata(ram_wdata), .boot_done(boot_done));

    flash_arbiter arbiter_i (.clk_2x(clk_2x), .reset(reset), .boot(boot_bus.server),
        .host(host_bus.server), .reader(reader_bus.client));

    qspi_reader reader_i (.clk_2x(clk_2x), .reset(reset), .bus(reader_bus.server),
        .csn(csn), .io_out(io_out), .io_en(io_en), .sck_run(sck_run), .io_in(io_in));

    flash_pin_adapter pins_i (.clk_2x(clk_2x), .reset(reset), .csn(csn),
        .io_out(io_out), .io_en(io_en), .sck_run(sck_run), .io_in(io_in),
        .flash_clk_ddr(flash_clk_ddr), .flash_csn(flash_csn),
        .flash_in_en(flash_in_en), .flash_in(flash_in), .flash_out(flash_out));

endmodule

/* source/qspi_reader.sv */
// ==================================================================
// Quad-SPI fast read engine
// Sends opcode and byte address on io0, waits out the dummy clocks,
// gathers eight nibbles into a word and answers on the read bus
// ==================================================================

`timescale 1ns/1ps

module qspi_reader (
    input  logic clk_2x,
    input  logic reset,
    flash_read_if.server bus,
    output logic csn,
    output logic [3:0] io_out,
    output logic [3:0] io_en,
    output logic sck_run,
    input  logic [3:0] io_in
);
    import flash_pkg::*;

    reader_state_e state;
    logic [4:0] bit_cnt;
    logic ack_q;
    logic [7:0] cmd_bits;
    // Byte address on the flash is the word address times four
    logic [addr_width+1:0] byte_addr;
    logic [word_width-1:0] shift_q;
    // Data clock markers delayed to line up with the pad registers
    logic sample_d1;
    logic sample_d2;

    assign cmd_bits = cmd_quad_read;

    // Nibbles arrive high first, so byte 0 lands in the top of shift_q
    // The word is little-endian, hence the byte swap on the way out
    assign bus.data = {shift_q[7:0], shift_q[15:8], shift_q[23:16], shift_q[31:24]};
    assign bus.ack = ack_q;

    // Pad values follow straight from the state and the bit counter
    always_comb begin
        csn = 1'b1;
        io_out = 4'b0000;
        io_en = 4'b0000;
        sck_run = 1'b0;
        case (state)
            rd_command: begin
                csn = 1'b0;
                sck_run = 1'b1;
                io_en = 4'b0001;
                io_out = {3'b000, cmd_bits[bit_cnt[2:0]]};
            end
            rd_address: begin
                csn = 1'b0;
                sck_run = 1'b1;
                io_en = 4'b0001;
                io_out = {3'b000, byte_addr[bit_cnt]};
            end
            // Flash owns the data lines from here on
            rd_dummy, rd_data: begin
                csn = 1'b0;
                sck_run = 1'b1;
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk_2x) begin
        if (reset) begin
            state <= rd_idle;
            bit_cnt <= 5'd0;
            ack_q <= 1'b0;
            sample_d1 <= 1'b0;
            sample_d2 <= 1'b0;
        end else begin
            sample_d1 <= (state == rd_data);
            sample_d2 <= sample_d1;
            case (state)
                rd_idle: begin
                    if (bus.req) begin
                        bit_cnt <= 5'd7;
                        state <= rd_command;
                    end
                end
                rd_command: begin
                    if (bit_cnt == 5'd0) begin
                        // Address goes out most significant bit first
                        bit_cnt <= 5'(addr_width + 1);
                        state <= rd_address;
                    end else begin
                        bit_cnt <= bit_cnt - 5'd1;
                    end
                end
                rd_address: begin
                    if (bit_cnt == 5'd0) begin
                        bit_cnt <= 5'(dummy_cycles - 1);
                        state <= rd_dummy;
                    end else begin
                        bit_cnt <= bit_cnt - 5'd1;
                    end
                end
                rd_dummy: begin
                    if (bit_cnt == 5'd0) begin
                        bit_cnt <= 5'd7;
                        state <= rd_data;
                    end else begin
                        bit_cnt <= bit_cnt - 5'd1;
                    end
                end
                rd_data: begin
                    if (bit_cnt == 5'd0) begin
                        state <= rd_finish;
                    end else begin
                        bit_cnt <= bit_cnt - 5'd1;
                    end
                end
                default: begin
                    // Last nibble is taken on this edge, so the word is whole
                    if (sample_d2 && !sample_d1) begin
                        ack_q <= 1'b1;
                    end else if (ack_q && !bus.req) begin
                        ack_q <= 1'b0;
                        state <= rd_idle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk_2x) begin
        if (state == rd_idle && bus.req) begin
            byte_addr <= {bus.addr, 2'b00};
        end
        if (sample_d2) begin
            shift_q <= {shift_q[word_width-5:0], io_in};
        end
    end

    a_no_drive_deselected: assert property (@(posedge clk_2x) disable iff (reset)
        csn |-> (io_en == 4'b0000));

    a_addr_stable: assert property (@(posedge clk_2x) disable iff (reset)
        (bus.req && $past(bus.req)) |-> $stable(bus.addr));

endmodule

/* src.f */
source/flash_pkg.sv
source/flash_read_if.sv
source/flash_arbiter.sv
source/qspi_reader.sv
source/flash_pin_adapter.sv
source/boot_copier.sv
source/flash_subsystem.sv
tests/flash_model.sv
tests/flash_subsystem_tb.sv

/* tests/flash_model.sv */
// ==================================================================
// Behavioral quad-SPI flash for the testbench
// Registers the pins, rebuilds the serial clock from the DDR pair
// and answers quad output fast reads with computed bytes
// ==================================================================

`timescale 1ns/1ps

module flash_model (
    input  logic clk_2x,
    input  logic [1:0] flash_clk_ddr,
    input  logic flash_csn,
    input  logic [3:0] flash_in,
    output logic [3:0] flash_out,
    output logic cmd_error
);

    // Serial clocks of each read phase, as seen by the device
    localparam int cmd_bits = 8;
    localparam int addr_bits = 24;
    localparam int dummy_clocks = 8;
    localparam int first_data_edge = cmd_bits + addr_bits + dummy_clocks;

    // Pin registers, loaded in the middle of each clk_2x cycle
    logic [1:0] pair_q = 2'b00;
    logic csn_q = 1'b1;
    logic [3:0] din_q = 4'h0;
    // Rebuilt serial clock
    logic sck = 1'b0;
    int rise_cnt = 0;
    logic [7:0] cmd_q = 8'h00;
    logic [23:0] addr_q = 24'h000000;
    logic [3:0] nibble_q = 4'h0;
    logic bad_cmd_q = 1'b0;

    // Byte k of a sequential read from base, high nibble on even k
    function automatic logic [3:0] nibble_at(input logic [23:0] base, input int k);
        logic [23:0] a;
        logic [7:0] b;
        a = base + 24'(k / 2);
        b = (a[7:0] ^ 8'hA5) + a[15:8];
        return (k % 2 == 0) ? b[7:4] : b[3:0];
    endfunction

    always @(negedge clk_2x) begin
        pair_q <= flash_clk_ddr;
        csn_q <= flash_csn;
        din_q <= flash_in;
    end

    // Bit 0 of the pair gives the high half of clk_2x and bit 1 the low half
    always @(posedge clk_2x or negedge clk_2x) begin
        sck <= clk_2x ? pair_q[0] : pair_q[1];
    end

    // Opcode and address come in on io0, most significant bit first
    always @(posedge sck or posedge csn_q) begin
        if (csn_q) begin
            rise_cnt <= 0;
        end else begin
            rise_cnt <= rise_cnt + 1;
            if (rise_cnt < cmd_bits) begin
                cmd_q <= {cmd_q[6:0], din_q[0]};
            end else if (rise_cnt < cmd_bits + addr_bits) begin
                addr_q <= {addr_q[22:0], din_q[0]};
            end
            // The opcode is whole once the first address bit arrives
            if (rise_cnt == cmd_bits && cmd_q != 8'h6B) begin
                bad_cmd_q <= 1'b1;
            end
        end
    end

    // Data nibbles change on the falling edge after the last dummy clock
    always @(negedge sck) begin
        if (rise_cnt >= first_data_edge) begin
            nibble_q <= nibble_at(addr_q, rise_cnt - first_data_edge);
        end
    end

    assign flash_out = csn_q ? 4'h0 : nibble_q;
    assign cmd_error = bad_cmd_q;

endmodule

/* tests/flash_subsystem_tb.sv */
// ==================================================================
// Testbench for the flash read subsystem
// Clock and reset, host read table, boot copy monitor, pad check,
// watchdog and closing summary
// ==================================================================

`timescale 1ns/1ps

module flash_subsystem_tb;
    import flash_pkg::*;

    localparam int num_reads = 8;
    // A read with arbitration takes under 60 cycles and the host holds fit in the margin
    localparam int watchdog_cycles = (num_reads + boot_words) * 60 + 1500;

    logic clk_2x = 1'b0;
    logic reset;
    logic boot_start;
    logic host_req;
    logic [addr_width-1:0] host_addr;
    logic host_ack;
    logic [word_width-1:0] host_data;
    logic ram_we;
    logic [ram_addr_width-1:0] ram_addr;
    logic [word_width-1:0] ram_wdata;
    logic boot_done;
    logic [1:0] flash_clk_ddr;
    logic flash_csn;
    logic [3:0] flash_in_en;
    logic [3:0] flash_in;
    logic [3:0] flash_out;
    logic cmd_error;

    // Stimulus table of host word address, expected word and cycles req is held after ack
    logic [addr_width-1:0] addr_tab [num_reads];
    logic [word_width-1:0] exp_tab [num_reads];
    int hold_tab [num_reads];

    int seed;
    int errors = 0;
    int checks = 0;
    int writes = 0;
    logic done_seen = 1'b0;

    flash_subsystem dut_i (.clk_2x(clk_2x), .reset(reset), .boot_start(boot_start),
        .host_req(host_req), .host_addr(host_addr), .host_ack(host_ack),
        .host_data(host_data), .ram_we(ram_we), .ram_addr(ram_addr), .ram_wdata(ram_wdata),
        .boot_done(boot_done), .flash_clk_ddr(flash_clk_ddr), .flash_csn(flash_csn),
        .flash_in_en(flash_in_en), .flash_in(flash_in), .flash_out(flash_out));

    flash_model flash_i (.clk_2x(clk_2x), .flash_clk_ddr(flash_clk_ddr),
        .flash_csn(flash_csn), .flash_in(flash_in), .flash_out(flash_out),
        .cmd_error(cmd_error));

    always #20 clk_2x = ~clk_2x;

    // Flash content is the low address byte xor A5 plus the middle address byte
    function automatic logic [7:0] rule_byte(input logic [23:0] a);
        return (a[7:0] ^ 8'hA5) + a[15:8];
    endfunction

    // Word w is little-endian over the bytes at 4w to 4w+3
    function automatic logic [word_width-1:0] rule_word(input logic [addr_width-1:0] w);
        logic [23:0] a;
        a = {w, 2'b00};
        return {rule_byte(a + 24'd3), rule_byte(a + 24'd2), rule_byte(a + 24'd1), rule_byte(a)};
    endfunction

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    // One four-phase read on the host port, entered and left on a falling edge
    task automatic host_read(input int i);
        host_addr = addr_tab[i];
        host_req = 1'b1;
        @(negedge clk_2x);
        // A serial read takes dozens of cycles, so ack cannot answer this early
        check_equal("host_ack", host_ack, 1'b0);
        while (!host_ack) begin
            @(negedge clk_2x);
        end
        check_equal("host_data", host_data, exp_tab[i]);
        // Holding req keeps the grant, so ack and data must not move
        repeat (hold_tab[i]) begin
            @(negedge clk_2x);
            check_equal("host_ack", host_ack, 1'b1);
            check_equal("host_data", host_data, exp_tab[i]);
        end
        host_req = 1'b0;
        @(negedge clk_2x);
        while (host_ack) begin
            @(negedge clk_2x);
        end
    endtask

    // Deselected flash must never see driven data lines
    always @(posedge clk_2x) begin
        if (flash_csn === 1'b1) begin
            check_equal("flash_in_en", flash_in_en, 4'h0);
        end
    end

    // Boot writes land in order, each with the flash word of its index
    always @(negedge clk_2x) begin
        if (ram_we === 1'b1) begin
            if (writes >= boot_words) begin
                errors++;
                $display("Unexpected RAM write at %0t ns after the boot block", $time);
            end else begin
                check_equal("ram_addr", ram_addr, writes);
                check_equal("ram_wdata", ram_wdata, rule_word(boot_base + addr_width'(writes)));
            end
            writes++;
        end
        if (boot_done === 1'b1 && !done_seen) begin
            check_equal("ram writes at boot_done", writes, boot_words);
            done_seen = 1'b1;
        end
        if (done_seen && boot_done !== 1'b1) begin
            errors++;
            $display("boot_done dropped at %0t ns before reset", $time);
        end
    end

    initial begin
        seed = 16;
        reset = 1'b1;
        boot_start = 1'b0;
        host_req = 1'b0;
        host_addr = '0;
        for (int i = 0; i < num_reads; i++) begin
            addr_tab[i] = addr_width'($random(seed));
            exp_tab[i] = rule_word(addr_tab[i]);
            hold_tab[i] = (i % 3) * 15;
        end
        repeat (8) @(negedge clk_2x);
        check_equal("flash_csn", flash_csn, 1'b1);
        check_equal("flash_in_en", flash_in_en, 4'h0);
        check_equal("flash_clk_ddr", flash_clk_ddr, 2'b00);
        check_equal("host_ack", host_ack, 1'b0);
        check_equal("ram_we", ram_we, 1'b0);
        check_equal("boot_done", boot_done, 1'b0);
        reset = 1'b0;
        @(negedge clk_2x);
        // First half of the table runs with the host alone on the bus
        for (int i = 0; i < num_reads / 2; i++) begin
            host_read(i);
        end
        boot_start = 1'b1;
        @(negedge clk_2x);
        boot_start = 1'b0;
        // Second half competes with the boot copy for the reader
        for (int i = num_reads / 2; i < num_reads; i++) begin
            host_read(i);
        end
        while (!boot_done) begin
            @(negedge clk_2x);
        end
        repeat (20) @(negedge clk_2x);
        check_equal("ram writes", writes, boot_words);
        check_equal("boot_done", boot_done, 1'b1);
        check_equal("flash opcode error", cmd_error, 1'b0);
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk_2x);
        $display("Timeout: the run did not finish within %0d clock cycles", watchdog_cycles);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule
